/* rtl/ooo_defines.svh */
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

`default_nettype none

// architectural register count
`define OOO_NREGS 32

// data path width
`define OOO_XLEN 32

// branch target and store address width
`define OOO_ALEN 16

// reorder buffer slots, power of two
`define OOO_ROB_DEPTH 8

`default_nettype wire

`endif

/* rtl/isa_pkg.sv */
`include "ooo_defines.svh"
`default_nettype none

package isa_pkg;

    // operation codes as issued by the decoder
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4,
        OP_BEQ = 3'd5,
        OP_SW  = 3'd6
    } opcode_e;

    // architectural register name
    typedef logic [$clog2(`OOO_NREGS)-1:0] regnm_t;

endpackage

`default_nettype wire

/* rtl/rob_pkg.sv */
`include "ooo_defines.svh"
`default_nettype none

package rob_pkg;

    // tag of an in-flight instruction, its reorder buffer slot
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] nick_t;

    // what happens when the entry retires
    typedef enum logic [1:0] {
        KIND_REG    = 2'd0,
        KIND_STORE  = 2'd1,
        KIND_BRANCH = 2'd2
    } entry_kind_e;

endpackage

`default_nettype wire

/* rtl/ooo_if.sv */
`include "ooo_defines.svh"
`default_nettype none

// completed result from the execution unit
interface ex_result_if;
    logic                 valid;
    rob_pkg::nick_t       nick;
    logic [`OOO_XLEN-1:0] data;
    logic                 taken;
    logic [`OOO_ALEN-1:0] target;

    modport source (output valid, nick, data, taken, target);
    modport sink   (input  valid, nick, data, taken, target);
endinterface

// in-order retirement towards the register file
interface commit_if;
    logic                 en;
    isa_pkg::regnm_t      regnm;
    logic [`OOO_XLEN-1:0] data;
    rob_pkg::nick_t       nick;

    modport source (output en, regnm, data, nick);
    modport sink   (input  en, regnm, data, nick);
endinterface

`default_nettype wire

/* rtl/reorder_buffer.sv */
`include "ooo_defines.svh"
`default_nettype none

module reorder_buffer (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    issue_en,
    input  wire isa_pkg::opcode_e  issue_op,
    input  wire isa_pkg::regnm_t   issue_rd,
    input  wire                    issue_pred,
    input  wire                    mul_busy,
    output logic                   issue_ready,
    output rob_pkg::nick_t         alloc_nick,
    output isa_pkg::regnm_t        alloc_rd,
    output logic                   alloc_en,
    ex_result_if.sink              res,
    input  wire                    store_done,
    output logic                   store_en,
    output rob_pkg::nick_t         store_nick,
    commit_if.source               cm,
    output logic                   flush,
    output logic                   redirect_valid,
    output logic [`OOO_ALEN-1:0]   redirect_pc
);

    localparam int DEPTH = `OOO_ROB_DEPTH;

    rob_pkg::entry_kind_e kind [DEPTH];
    isa_pkg::regnm_t      rd_q [DEPTH];
    logic [`OOO_XLEN-1:0] data_q [DEPTH];
    logic [`OOO_ALEN-1:0] target_q [DEPTH];
    logic [DEPTH-1:0]     done;
    logic [DEPTH-1:0]     pred;
    logic [DEPTH-1:0]     taken;

    rob_pkg::nick_t         head;
    rob_pkg::nick_t         tail;
    logic [$clog2(DEPTH):0] count;
    logic                   store_busy;

    rob_pkg::entry_kind_e issue_kind;
    rob_pkg::entry_kind_e head_kind;
    logic                 fire;
    logic                 head_done;
    logic                 retire;
    logic                 mispredict;

    always_comb begin
        case (issue_op)
            isa_pkg::OP_SW:  issue_kind = rob_pkg::KIND_STORE;
            isa_pkg::OP_BEQ: issue_kind = rob_pkg::KIND_BRANCH;
            default:         issue_kind = rob_pkg::KIND_REG;
        endcase
    end

    // a new multiply waits while the multiplier is still occupied
    assign issue_ready = (count != DEPTH) && !flush &&
                         !(issue_op == isa_pkg::OP_MUL && mul_busy);
    assign fire        = issue_en && issue_ready;

    assign alloc_en   = fire;
    assign alloc_nick = tail;
    assign alloc_rd   = (issue_kind == rob_pkg::KIND_REG) ? issue_rd : '0;

    assign head_kind = kind[head];
    assign head_done = (count != '0) && done[head] && !flush;

    // stores hand off once, then wait for the store unit
    assign store_en   = head_done && head_kind == rob_pkg::KIND_STORE && !store_busy;
    assign store_nick = head;

    assign retire     = head_done && (head_kind != rob_pkg::KIND_STORE || store_done);
    assign mispredict = retire && head_kind == rob_pkg::KIND_BRANCH &&
                        (taken[head] != pred[head]);

    assign cm.en    = retire && head_kind == rob_pkg::KIND_REG;
    assign cm.regnm = rd_q[head];
    assign cm.data  = data_q[head];
    assign cm.nick  = head;

    assign redirect_valid = flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            done       <= '0;
            store_busy <= 1'b0;
            flush      <= 1'b0;
        end else if (flush) begin
            // drop everything younger than the mispredicted branch
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            done       <= '0;
            store_busy <= 1'b0;
            flush      <= 1'b0;
        end else begin
            flush <= mispredict;
            if (fire) begin
                tail       <= tail + 1'b1;
                done[tail] <= (issue_kind == rob_pkg::KIND_STORE);
            end
            if (res.valid) begin
                done[res.nick] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            if (store_en) begin
                store_busy <= 1'b1;
            end else if (store_done) begin
                store_busy <= 1'b0;
            end
            case ({fire, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            kind[tail]  <= issue_kind;
            rd_q[tail]  <= alloc_rd;
            pred[tail]  <= issue_pred;
            taken[tail] <= 1'b0;
        end
        if (res.valid) begin
            data_q[res.nick]   <= res.data;
            taken[res.nick]    <= res.taken;
            target_q[res.nick] <= res.target;
        end
        if (mispredict) begin
            redirect_pc <= target_q[head];
        end
    end

endmodule

`default_nettype wire

/* rtl/rename_regfile.sv */
`include "ooo_defines.svh"
`default_nettype none

module rename_regfile (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire isa_pkg::regnm_t  rs1,
    input  wire isa_pkg::regnm_t  rs2,
    output logic [`OOO_XLEN-1:0]  rs1_data,
    output logic [`OOO_XLEN-1:0]  rs2_data,
    output logic                  src_pending,
    input  wire                   alloc_en,
    input  wire rob_pkg::nick_t   alloc_nick,
    input  wire isa_pkg::regnm_t  alloc_rd,
    commit_if.sink                cm,
    input  wire                   flush
);

    logic [`OOO_XLEN-1:0]  regs [`OOO_NREGS];
    logic [`OOO_NREGS-1:0] pend;
    rob_pkg::nick_t        ptag [`OOO_NREGS];

    // x0 is never written and never pending
    assign rs1_data    = regs[rs1];
    assign rs2_data    = regs[rs2];
    assign src_pending = pend[rs1] | pend[rs2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= '0;
            for (int i = 0; i < `OOO_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (cm.en && cm.regnm != '0) begin
                regs[cm.regnm] <= cm.data;
                // a younger writer keeps the register pending
                if (ptag[cm.regnm] == cm.nick) begin
                    pend[cm.regnm] <= 1'b0;
                end
            end
            if (flush) begin
                pend <= '0;
            end else if (alloc_en && alloc_rd != '0) begin
                pend[alloc_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            ptag[alloc_rd] <= alloc_nick;
        end
    end

endmodule

`default_nettype wire

/* rtl/exec_unit.sv */
`include "ooo_defines.svh"
`default_nettype none

module exec_unit (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    start,
    input  wire isa_pkg::opcode_e  op,
    input  wire rob_pkg::nick_t    nick,
    input  wire [`OOO_XLEN-1:0]    a,
    input  wire [`OOO_XLEN-1:0]    b,
    input  wire [`OOO_ALEN-1:0]    imm_target,
    input  wire                    flush,
    output logic                   mul_busy,
    ex_result_if.source            res
);

    typedef struct packed {
        rob_pkg::nick_t       nick;
        logic [`OOO_XLEN-1:0] data;
        logic                 taken;
        logic [`OOO_ALEN-1:0] target;
    } result_t;

    result_t    s_d;
    result_t    s_q;
    result_t    h_q;
    result_t    out_q;
    result_t    mul_q [3];
    logic       s_v;
    logic       h_v;
    logic [2:0] mul_v;

    always_comb begin
        s_d = '{nick: nick, data: '0, taken: 1'b0, target: imm_target};
        case (op)
            isa_pkg::OP_ADD: s_d.data = a + b;
            isa_pkg::OP_SUB: s_d.data = a - b;
            isa_pkg::OP_AND: s_d.data = a & b;
            isa_pkg::OP_XOR: s_d.data = a ^ b;
            isa_pkg::OP_BEQ: s_d.taken = (a == b);
            default:         s_d.data = '0;
        endcase
    end

    // spacing multiplies three apart keeps the holding register sufficient
    assign mul_busy = mul_v[0] | mul_v[1];

    // multiply first, then the held simple result, then the fresh one
    assign out_q      = mul_v[2] ? mul_q[2] : (h_v ? h_q : s_q);
    assign res.valid  = mul_v[2] | h_v | s_v;
    assign res.nick   = out_q.nick;
    assign res.data   = out_q.data;
    assign res.taken  = out_q.taken;
    assign res.target = out_q.target;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_v   <= 1'b0;
            h_v   <= 1'b0;
            mul_v <= '0;
        end else if (flush) begin
            s_v   <= 1'b0;
            h_v   <= 1'b0;
            mul_v <= '0;
        end else begin
            s_v   <= start && op != isa_pkg::OP_MUL && op != isa_pkg::OP_SW;
            mul_v <= {mul_v[1:0], start && op == isa_pkg::OP_MUL};
            h_v   <= mul_v[2] ? (h_v | s_v) : (h_v & s_v);
        end
    end

    always_ff @(posedge clk) begin
        s_q      <= s_d;
        mul_q[0] <= '{nick: nick, data: a * b, taken: 1'b0, target: imm_target};
        mul_q[1] <= mul_q[0];
        mul_q[2] <= mul_q[1];
        // park when blocked by a multiply, or refill while draining
        if (mul_v[2] ^ h_v) begin
            h_q <= s_q;
        end
    end

endmodule

`default_nettype wire

/* rtl/store_unit.sv */
`include "ooo_defines.svh"
`default_nettype none

module store_unit (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   capture_en,
    input  wire rob_pkg::nick_t   capture_nick,
    input  wire [`OOO_ALEN-1:0]   addr,
    input  wire [`OOO_XLEN-1:0]   data,
    input  wire                   store_en,
    input  wire rob_pkg::nick_t   store_nick,
    input  wire                   flush,
    output logic                  store_done,
    output logic                  mem_we,
    output logic [`OOO_ALEN-1:0]  mem_addr,
    output logic [`OOO_XLEN-1:0]  mem_data
);

    localparam int DEPTH   = `OOO_ROB_DEPTH;
    localparam int DMEM_AW = 4;

    logic [`OOO_ALEN-1:0] tab_addr [DEPTH];
    logic [`OOO_XLEN-1:0] tab_data [DEPTH];
    logic [DEPTH-1:0]     tab_v;
    logic [`OOO_XLEN-1:0] dmem [2**DMEM_AW];

    // word-addressed, reads back what was just written
    assign mem_data = dmem[mem_addr[DMEM_AW+1:2]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tab_v      <= '0;
            store_done <= 1'b0;
            mem_we     <= 1'b0;
        end else begin
            store_done <= store_en;
            mem_we     <= store_en && tab_v[store_nick];
            if (flush) begin
                tab_v <= '0;
            end else begin
                if (capture_en) begin
                    tab_v[capture_nick] <= 1'b1;
                end
                if (store_en) begin
                    tab_v[store_nick] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture_en) begin
            tab_addr[capture_nick] <= addr;
            tab_data[capture_nick] <= data;
        end
        if (store_en && tab_v[store_nick]) begin
            mem_addr <= tab_addr[store_nick];
            dmem[tab_addr[store_nick][DMEM_AW+1:2]] <= tab_data[store_nick];
        end
    end

endmodule

`default_nettype wire

/* rtl/ooo_core_top.sv */
`include "ooo_defines.svh"
`default_nettype none

module ooo_core_top (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    issue_en,
    input  wire isa_pkg::opcode_e  issue_op,
    input  wire isa_pkg::regnm_t   issue_rd,
    input  wire isa_pkg::regnm_t   issue_rs1,
    input  wire isa_pkg::regnm_t   issue_rs2,
    input  wire [`OOO_ALEN-1:0]    issue_imm,
    input  wire                    issue_pred,
    output logic                   issue_ready,
    output logic                   commit_en,
    output isa_pkg::regnm_t        commit_rd,
    output logic [`OOO_XLEN-1:0]   commit_data,
    output logic                   mem_we,
    output logic [`OOO_ALEN-1:0]   mem_addr,
    output logic [`OOO_XLEN-1:0]   mem_data,
    output logic                   redirect_valid,
    output logic [`OOO_ALEN-1:0]   redirect_pc
);

    ex_result_if res_bus ();
    commit_if    cm_bus ();

    logic                 rob_ready;
    logic                 src_pending;
    logic                 issue_fire;
    logic                 mul_busy;
    logic                 alloc_en;
    rob_pkg::nick_t       alloc_nick;
    isa_pkg::regnm_t      alloc_rd;
    logic                 store_en;
    rob_pkg::nick_t       store_nick;
    logic                 store_done;
    logic                 flush;
    logic [`OOO_XLEN-1:0] rs1_data;
    logic [`OOO_XLEN-1:0] rs2_data;

    // operands are read at issue, so wait until both sources have committed
    assign issue_ready = rob_ready && !src_pending;
    assign issue_fire  = issue_en && issue_ready;

    assign commit_en   = cm_bus.en;
    assign commit_rd   = cm_bus.regnm;
    assign commit_data = cm_bus.data;

    reorder_buffer i_reorder_buffer (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_en       (issue_fire),
        .issue_op       (issue_op),
        .issue_rd       (issue_rd),
        .issue_pred     (issue_pred),
        .mul_busy       (mul_busy),
        .issue_ready    (rob_ready),
        .alloc_nick     (alloc_nick),
        .alloc_rd       (alloc_rd),
        .alloc_en       (alloc_en),
        .res            (res_bus.sink),
        .store_done     (store_done),
        .store_en       (store_en),
        .store_nick     (store_nick),
        .cm             (cm_bus.source),
        .flush          (flush),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    rename_regfile i_rename_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .rs1         (issue_rs1),
        .rs2         (issue_rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .src_pending (src_pending),
        .alloc_en    (alloc_en),
        .alloc_nick  (alloc_nick),
        .alloc_rd    (alloc_rd),
        .cm          (cm_bus.sink),
        .flush       (flush)
    );

    exec_unit i_exec_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (issue_fire),
        .op         (issue_op),
        .nick       (alloc_nick),
        .a          (rs1_data),
        .b          (rs2_data),
        .imm_target (issue_imm),
        .flush      (flush),
        .mul_busy   (mul_busy),
        .res        (res_bus.source)
    );

    // store data is rs2, the address comes from the immediate
    store_unit i_store_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .capture_en   (issue_fire && issue_op == isa_pkg::OP_SW),
        .capture_nick (alloc_nick),
        .addr         (issue_imm),
        .data         (rs2_data),
        .store_en     (store_en),
        .store_nick   (store_nick),
        .flush        (flush),
        .store_done   (store_done),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data)
    );

endmodule

`default_nettype wire

/* verification/ooo_assert.sv */
`include "ooo_defines.svh"
`default_nettype none

module ooo_assert (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          flush,
    input wire                          retire,
    input wire [$clog2(`OOO_ROB_DEPTH):0] count
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH = `OOO_ROB_DEPTH;

    count_bounded: assert property (
        @(posedge clk) disable iff (!rst_n) count <= DEPTH
    ) else $error("reorder buffer count above its depth");

    // flush is a single-cycle pulse
    flush_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) flush |=> !flush
    ) else $error("flush held longer than one cycle");

    no_retire_in_flush: assert property (
        @(posedge clk) disable iff (!rst_n) flush |-> !retire
    ) else $error("entry retired during flush");

endmodule

bind reorder_buffer ooo_assert i_ooo_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .flush  (flush),
    .retire (retire),
    .count  (count)
);

`default_nettype wire

/* verification/ooo_tb.sv */
`include "ooo_defines.svh"
`default_nettype none

module ooo_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROW_W      = 8;
    localparam int MAX_ROWS   = 64;
    localparam int RST_CYCLES = 10;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 issue_en;
    isa_pkg::opcode_e     issue_op;
    isa_pkg::regnm_t      issue_rd;
    isa_pkg::regnm_t      issue_rs1;
    isa_pkg::regnm_t      issue_rs2;
    logic [`OOO_ALEN-1:0] issue_imm;
    logic                 issue_pred;
    logic                 issue_ready;
    logic                 commit_en;
    isa_pkg::regnm_t      commit_rd;
    logic [`OOO_XLEN-1:0] commit_data;
    logic                 mem_we;
    logic [`OOO_ALEN-1:0] mem_addr;
    logic [`OOO_XLEN-1:0] mem_data;
    logic                 redirect_valid;
    logic [`OOO_ALEN-1:0] redirect_pc;

    logic [31:0] gold [MAX_ROWS*ROW_W];
    int          ins_row [$];
    int          cmt_row [$];
    int          st_row [$];
    int          redir_row [$];
    int          n_commits;
    int          n_stores;
    int          n_redirects;
    int          errors;
    bit          loaded;
    bit          redirect_now;

    ooo_core_top i_ooo_core_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_en       (issue_en),
        .issue_op       (issue_op),
        .issue_rd       (issue_rd),
        .issue_rs1      (issue_rs1),
        .issue_rs2      (issue_rs2),
        .issue_imm      (issue_imm),
        .issue_pred     (issue_pred),
        .issue_ready    (issue_ready),
        .commit_en      (commit_en),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_data       (mem_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
            abort_run("value check failed");
        end
    endtask

    function automatic logic [31:0] field(input int row, input int col);
        return gold[row*ROW_W + col];
    endfunction

    task automatic load_golden();
        int row;
        for (int i = 0; i < MAX_ROWS*ROW_W; i++) begin
            gold[i] = '0;
        end
        $readmemh("verification/ooo_golden.mem", gold);
        row = 0;
        // a zero type column ends the records
        while (row < MAX_ROWS && gold[row*ROW_W] != 0) begin
            case (gold[row*ROW_W])
                1:       ins_row.push_back(row);
                2:       cmt_row.push_back(row);
                3:       st_row.push_back(row);
                4:       redir_row.push_back(row);
                default: abort_run("golden file holds a record of unknown type");
            endcase
            row++;
        end
        if (ins_row.size() == 0) begin
            abort_run("golden file holds no instruction lines");
        end
        loaded = 1'b1;
    endtask

    task automatic drive_line(input int r);
        logic [31:0] op_w;
        op_w       = field(r, 1);
        issue_en   = 1'b1;
        issue_op   = isa_pkg::opcode_e'(op_w[2:0]);
        issue_rd   = isa_pkg::regnm_t'(field(r, 2));
        issue_rs1  = isa_pkg::regnm_t'(field(r, 3));
        issue_rs2  = isa_pkg::regnm_t'(field(r, 4));
        issue_imm  = `OOO_ALEN'(field(r, 5));
        issue_pred = field(r, 6) != 0;
    endtask

    // commit, store and redirect outputs hold still between rising edges
    task automatic watch_outputs();
        int r;
        redirect_now = 1'b0;
        if (commit_en) begin
            if (n_commits >= cmt_row.size()) begin
                abort_run("a register commit arrived beyond the expected records");
            end else begin
                r = cmt_row[n_commits];
                check_value("commit_rd", 32'(commit_rd), field(r, 1));
                check_value("commit_data", commit_data, field(r, 2));
                n_commits++;
            end
        end
        if (mem_we) begin
            if (n_stores >= st_row.size()) begin
                abort_run("a memory write arrived beyond the expected records");
            end else begin
                r = st_row[n_stores];
                check_value("mem_addr", 32'(mem_addr), field(r, 1));
                check_value("mem_data", mem_data, field(r, 2));
                check_value("commit count at store", 32'(n_commits), field(r, 3));
                n_stores++;
            end
        end
        if (redirect_valid) begin
            if (n_redirects >= redir_row.size()) begin
                abort_run("a redirect arrived that the golden file does not expect");
            end else begin
                r = redir_row[n_redirects];
                check_value("redirect_pc", 32'(redirect_pc), field(r, 1));
                check_value("commit count at redirect", 32'(n_commits), field(r, 2));
                check_value("issue_ready", 32'(issue_ready), 32'd0);
                n_redirects++;
                redirect_now = 1'b1;
            end
        end
    endtask

    initial begin
        wait (loaded);
        repeat (RST_CYCLES + 40 * ins_row.size()) @(posedge clk);
        abort_run("watchdog expired before all expected records were seen");
    end

    initial begin
        int idx;
        bit hold;
        rst_n        = 1'b0;
        issue_en     = 1'b0;
        issue_op     = isa_pkg::OP_ADD;
        issue_rd     = '0;
        issue_rs1    = '0;
        issue_rs2    = '0;
        issue_imm    = '0;
        issue_pred   = 1'b0;
        n_commits    = 0;
        n_stores     = 0;
        n_redirects  = 0;
        errors       = 0;
        loaded       = 1'b0;
        redirect_now = 1'b0;
        idx          = 0;
        hold         = 1'b0;
        load_golden();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("issue_ready", 32'(issue_ready), 32'd1);
        check_value("commit_en", 32'(commit_en), 32'd0);
        check_value("mem_we", 32'(mem_we), 32'd0);
        check_value("redirect_valid", 32'(redirect_valid), 32'd0);

        while (idx < ins_row.size() || hold || n_commits < cmt_row.size() ||
               n_stores < st_row.size() || n_redirects < redir_row.size()) begin
            watch_outputs();
            if (redirect_now) begin
                // skip what is left of the flushed group
                if (!hold) begin
                    while (idx < ins_row.size() && field(ins_row[idx], 7) == 0) begin
                        idx++;
                    end
                    idx++;
                end
                hold = 1'b0;
            end
            if (!hold && idx < ins_row.size()) begin
                drive_line(ins_row[idx]);
                #1;
                if (issue_ready) begin
                    hold = field(ins_row[idx], 7) != 0;
                    idx++;
                end
            end else begin
                issue_en = 1'b0;
            end
            @(negedge clk);
        end
        issue_en = 1'b0;

        // nothing from a flushed group may show up late
        repeat (20) begin
            watch_outputs();
            @(negedge clk);
        end

        if (errors == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abort_run("errors were recorded during the run");
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/rob_pkg.sv
rtl/ooo_if.sv
rtl/reorder_buffer.sv
rtl/rename_regfile.sv
rtl/exec_unit.sv
rtl/store_unit.sv
rtl/ooo_core_top.sv
verification/ooo_assert.sv
verification/ooo_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it; the exit status carries the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module ooo_tb -f verilog.f -o ooo_sim
./obj_dir/ooo_sim

/* verification/ooo_golden.mem */
// columns: type f1 f2 f3 f4 f5 f6 f7; type 1 instruction: op rd rs1 rs2 imm pred stop
// type 2 commit: rd data; type 3 store: addr data commits_before; type 4 redirect: pc commits_before
1 0 1  0 0 0   0 0  // add x1
1 1 2  0 0 0   0 0  // sub x2
1 3 3  0 0 0   0 0  // xor x3
1 4 4  1 2 0   0 0  // mul x4, x1, x2
1 0 5  0 0 0   0 0  // add x5 finishes before the mul
1 2 6  4 5 0   0 0  // and x6, x4, x5 waits on both
1 6 0  0 6 10  0 0  // sw x6 to 0x10
1 4 7  0 0 0   0 0  // mul x7
1 4 8  0 0 0   0 0  // mul x8 behind the busy multiplier
1 5 0  0 0 100 0 0  // beq predicted not taken, taken
1 0 1f 0 0 0   0 0  // wrong path
1 6 0  0 0 20  0 1  // wrong path store, end of group
1 5 0  0 0 200 1 0  // beq predicted taken
1 0 9  7 8 0   0 0  // add x9, x7, x8
1 6 0  0 9 34  0 0  // sw x9 to 0x34
1 5 0  0 0 340 0 0  // beq mispredicted
1 0 1e 0 0 0   0 1  // wrong path, end of group
1 1 a  9 0 0   0 0  // sub x10, x9, x0
1 3 b  a 6 0   0 0  // xor x11, x10, x6
2 1 0  0 0 0   0 0
2 2 0  0 0 0   0 0
2 3 0  0 0 0   0 0
2 4 0  0 0 0   0 0
2 5 0  0 0 0   0 0
2 6 0  0 0 0   0 0
2 7 0  0 0 0   0 0
2 8 0  0 0 0   0 0
2 9 0  0 0 0   0 0
2 a 0  0 0 0   0 0
2 b 0  0 0 0   0 0
3 10 0 6 0 0   0 0
3 34 0 9 0 0   0 0
4 100 8 0 0 0  0 0
4 340 9 0 0 0  0 0
